/* hdl/fx2_usb_pkg.sv */
// FX2 USB bridge package
// shared word type, FX2 Slave FIFO pin structs, endpoint addresses,
// bridge FIFO sizing and the forced packet-end timeout
package fx2_usb_pkg;

   // one 16-bit word, same on the debug network and the FX2 data bus
   typedef logic [15:0] word_t;

   // FX2 control outputs, every bit is active low
   typedef struct packed {
      logic       slrd;
      logic       slwr;
      logic       sloe;
      logic       pktend;
      logic [1:0] fifoadr;
   } fx2_ctrl_t;

   // FX2 flag inputs, every bit is active low
   typedef struct packed {
      // OUT endpoint empty, low means nothing to read
      logic epout_empty_n;
      // IN endpoint full
      logic epin_full_n;
      // IN endpoint has a single slot left
      logic epin_almost_full_n;
   } fx2_flags_t;

   // slave FIFO addresses
   localparam logic [1:0] EP2_ADDR = 2'b00;
   localparam logic [1:0] EP6_ADDR = 2'b10;

   // bridge FIFO sizing, both directions use the same depth
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

   // fx2_clk cycles without a write before a short packet is committed
   localparam int FORCE_SEND_TIMEOUT = 1024;
   localparam int IDLE_CNT_W         = $clog2(FORCE_SEND_TIMEOUT + 1);

   // port controller states
   typedef enum logic [1:0] {
      IDLE = 2'b00,
      SEND = 2'b01,
      RCV  = 2'b10
   } port_state_t;

endpackage

/* hdl/cdc_fifo.sv */
// Dual-clock first-word-fall-through FIFO
// binary and Gray pointers per side, each Gray pointer is passed to the
// other clock through a two-flop synchronizer; full and empty are
// derived locally against the synchronized remote pointer
module cdc_fifo import fx2_usb_pkg::*; (
   input  logic  rst,
   // write side
   input  logic  wr_clk,
   input  logic  wr_en,
   input  word_t din,
   output logic  full,
   // read side
   input  logic  rd_clk,
   input  logic  rd_en,
   output word_t dout,
   output logic  valid
);

   // storage, no reset needed on payload
   word_t mem [FIFO_DEPTH];

   // write domain pointers
   logic [FIFO_AW:0] wr_bin;
   logic [FIFO_AW:0] wr_gray;
   logic [FIFO_AW:0] wr_bin_nxt;
   // read pointer as seen from the write domain
   logic [FIFO_AW:0] wr_rgray_s1;
   logic [FIFO_AW:0] wr_rgray_s2;

   // read domain pointers
   logic [FIFO_AW:0] rd_bin;
   logic [FIFO_AW:0] rd_gray;
   logic [FIFO_AW:0] rd_bin_nxt;
   // write pointer as seen from the read domain
   logic [FIFO_AW:0] rd_wgray_s1;
   logic [FIFO_AW:0] rd_wgray_s2;

   logic wr_do;
   logic rd_do;

   // accepted transfers only
   assign wr_do = wr_en & ~full;
   assign rd_do = rd_en & valid;

   assign wr_bin_nxt = wr_bin + 1'b1;
   assign rd_bin_nxt = rd_bin + 1'b1;

   // full when the pointers differ only in the two top Gray bits
   assign full = (wr_gray == {~wr_rgray_s2[FIFO_AW:FIFO_AW-1],
                              wr_rgray_s2[FIFO_AW-2:0]});

   // empty when the Gray pointers match
   assign valid = (rd_gray != rd_wgray_s2);

   // head word falls through to the output
   assign dout = mem[rd_bin[FIFO_AW-1:0]];

   always_ff @(posedge wr_clk) begin
      if (wr_do) begin
         mem[wr_bin[FIFO_AW-1:0]] <= din;
      end
   end

   // write pointer update, reset sampled in wr_clk
   always_ff @(posedge wr_clk) begin
      if (rst) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else if (wr_do) begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
      end
   end

   // bring read pointer across, two flops
   always_ff @(posedge wr_clk) begin
      if (rst) begin
         wr_rgray_s1 <= '0;
         wr_rgray_s2 <= '0;
      end else begin
         wr_rgray_s1 <= rd_gray;
         wr_rgray_s2 <= wr_rgray_s1;
      end
   end

   // read pointer update, reset sampled in rd_clk
   always_ff @(posedge rd_clk) begin
      if (rst) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else if (rd_do) begin
         rd_bin  <= rd_bin_nxt;
         rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      end
   end

   // bring write pointer across, two flops
   always_ff @(posedge rd_clk) begin
      if (rst) begin
         rd_wgray_s1 <= '0;
         rd_wgray_s2 <= '0;
      end else begin
         rd_wgray_s1 <= wr_gray;
         rd_wgray_s2 <= rd_wgray_s1;
      end
   end

endmodule

/* hdl/fx2_slave_fifo_ctrl.sv */
// FX2 Slave FIFO port controller
// arbitrates between EP6 writes and EP2 reads, one word per fx2_clk,
// and commits a short IN packet when nothing was written for a while
module fx2_slave_fifo_ctrl import fx2_usb_pkg::*; (
   input  logic       fx2_clk,
   input  logic       rst,
   // FX2 pins
   input  fx2_flags_t fx2_flags,
   output fx2_ctrl_t  fx2_ctrl,
   // send FIFO read side
   input  logic       send_valid,
   output logic       send_pop,
   // receive FIFO write side
   input  logic       rcv_full,
   output logic       rcv_push
);

   port_state_t state;
   port_state_t nxt_state;

   // set once a word moved in the current state visit
   logic moved;

   logic can_send;
   logic can_rcv;

   logic slwr_n;
   logic slrd_n;

   logic [IDLE_CNT_W-1:0] idle_cnt;
   logic force_send;

   // flags are active low, high means room or data
   // almost full leaves one slot unused, so no word is ever lost
   assign can_send = send_valid & fx2_flags.epin_full_n & fx2_flags.epin_almost_full_n;
   assign can_rcv  = fx2_flags.epout_empty_n & ~rcv_full;

   // next state and strobes
   always_comb begin
      nxt_state = state;
      slwr_n    = 1'b1;
      slrd_n    = 1'b1;
      case (state)
         IDLE: begin
            // sending wins when both are possible
            if (can_send) begin
               nxt_state = SEND;
            end else if (can_rcv) begin
               nxt_state = RCV;
            end
         end
         SEND: begin
            // hand over to the reader after at least one word
            if (can_rcv && moved) begin
               nxt_state = RCV;
            end else if (can_send) begin
               slwr_n = 1'b0;
            end else if (can_rcv) begin
               nxt_state = RCV;
            end else begin
               nxt_state = IDLE;
            end
         end
         RCV: begin
            // give the writer its turn, so directions alternate under load
            if (can_send && moved) begin
               nxt_state = SEND;
            end else if (can_rcv) begin
               slrd_n = 1'b0;
            end else if (can_send) begin
               nxt_state = SEND;
            end else begin
               nxt_state = IDLE;
            end
         end
         default: begin
            nxt_state = IDLE;
         end
      endcase
   end

   always_ff @(posedge fx2_clk) begin
      if (rst) begin
         state <= IDLE;
         moved <= 1'b0;
      end else begin
         state <= nxt_state;
         // cleared on every state change
         if (nxt_state != state) begin
            moved <= 1'b0;
         end else if (!slwr_n || !slrd_n) begin
            moved <= 1'b1;
         end
      end
   end

   // idle counter, restarts on each written word and after a forced pktend
   always_ff @(posedge fx2_clk) begin
      if (rst || !slwr_n || force_send) begin
         idle_cnt <= '0;
      end else begin
         idle_cnt <= idle_cnt + 1'b1;
      end
   end

   assign force_send = (idle_cnt == IDLE_CNT_W'(FORCE_SEND_TIMEOUT));

   // FIFO side strobes follow the FX2 strobes
   assign send_pop = ~slwr_n;
   assign rcv_push = ~slrd_n;

   // FX2 side, output enable tracks the read strobe
   assign fx2_ctrl.slrd    = slrd_n;
   assign fx2_ctrl.slwr    = slwr_n;
   assign fx2_ctrl.sloe    = slrd_n;
   assign fx2_ctrl.pktend  = ~force_send;
   // EP6 held for the whole SEND visit, gives address setup before slwr
   assign fx2_ctrl.fifoadr = (state == SEND) ? EP6_ADDR : EP2_ADDR;

endmodule

/* hdl/fx2_usb_bridge.sv */
// Debug network to FX2 USB bridge
// send path: network out side -> clk_sys/fx2_clk FIFO -> FX2 EP6
// receive path: FX2 EP2 -> fx2_clk/clk_sys FIFO -> network in side
module fx2_usb_bridge import fx2_usb_pkg::*; (
   input  logic       clk_sys,
   input  logic       fx2_clk,
   input  logic       rst,
   // network out side, words toward USB
   input  word_t      out_data,
   input  logic       out_valid,
   output logic       out_ready,
   // network in side, words from USB
   output word_t      in_data,
   output logic       in_valid,
   input  logic       in_ready,
   // FX2 Slave FIFO port
   input  fx2_flags_t fx2_flags,
   input  word_t      fx2_fd_in,
   output word_t      fx2_fd_out,
   output fx2_ctrl_t  fx2_ctrl
);

   logic send_full;
   logic send_valid;
   logic send_pop;
   logic rcv_full;
   logic rcv_push;

   // network may push while there is room
   assign out_ready = ~send_full;

   // network to USB, head word drives the FX2 data bus directly
   cdc_fifo i_send_fifo (
      .rst    (rst),
      .wr_clk (clk_sys),
      .wr_en  (out_valid),
      .din    (out_data),
      .full   (send_full),
      .rd_clk (fx2_clk),
      .rd_en  (send_pop),
      .dout   (fx2_fd_out),
      .valid  (send_valid)
   );

   // USB to network, valid doubles as the network valid
   cdc_fifo i_rcv_fifo (
      .rst    (rst),
      .wr_clk (fx2_clk),
      .wr_en  (rcv_push),
      .din    (fx2_fd_in),
      .full   (rcv_full),
      .rd_clk (clk_sys),
      .rd_en  (in_ready),
      .dout   (in_data),
      .valid  (in_valid)
   );

   fx2_slave_fifo_ctrl i_ctrl (
      .fx2_clk    (fx2_clk),
      .rst        (rst),
      .fx2_flags  (fx2_flags),
      .fx2_ctrl   (fx2_ctrl),
      .send_valid (send_valid),
      .send_pop   (send_pop),
      .rcv_full   (rcv_full),
      .rcv_push   (rcv_push)
   );

endmodule

/* verification/fx2_chip_model.sv */
// FX2 Slave FIFO behavioral model
// EP2 OUT and EP6 IN buffers with active-low flags; logs every word
// written to EP6 and every pktend pulse with its fx2_clk cycle
module fx2_chip_model import fx2_usb_pkg::*; (
   input  logic       fx2_clk,
   input  logic       rst,
   input  fx2_ctrl_t  fx2_ctrl,
   input  word_t      fx2_fd_out,
   output fx2_flags_t fx2_flags,
   output word_t      fx2_fd_in
);

   localparam int EP_DEPTH = 8;

   // OUT endpoint contents, head is presented on fd_in
   word_t ep2_q[$];
   // every word the bridge wrote into EP6, in order
   word_t ep6_log[$];
   // cycle number of each pktend pulse
   int    pkt_log[$];
   int    ep6_level     = 0;
   int    cycle         = 0;
   int    last_wr_cycle = 0;
   // host stops draining EP6 and flags read as full
   logic  ep6_stall     = 1'b0;

   initial begin
      fx2_flags <= '{epout_empty_n: 1'b0, epin_full_n: 1'b1, epin_almost_full_n: 1'b1};
      fx2_fd_in <= '0;
   end

   always @(posedge fx2_clk) begin
      if (rst) begin
         ep6_level = 0;
      end else begin
         cycle = cycle + 1;
         // a write into a full buffer is dropped, as the real chip would
         if (!fx2_ctrl.slwr && fx2_ctrl.fifoadr == EP6_ADDR && ep6_level < EP_DEPTH) begin
            ep6_log.push_back(fx2_fd_out);
            ep6_level     = ep6_level + 1;
            last_wr_cycle = cycle;
         end
         // host takes one word per cycle
         if (!ep6_stall && ep6_level > 0)
            ep6_level = ep6_level - 1;
         if (!fx2_ctrl.slrd && fx2_ctrl.fifoadr == EP2_ADDR && ep2_q.size() > 0)
            void'(ep2_q.pop_front());
         if (!fx2_ctrl.pktend)
            pkt_log.push_back(cycle);
      end
      // flags and head word reflect the buffers after this edge, driven just after it
      fx2_fd_in                    <= #1 (ep2_q.size() > 0) ? ep2_q[0] : '0;
      fx2_flags.epout_empty_n      <= #1 (ep2_q.size() > 0);
      fx2_flags.epin_full_n        <= #1 !(ep6_stall || ep6_level >= EP_DEPTH);
      fx2_flags.epin_almost_full_n <= #1 !(ep6_stall || ep6_level >= EP_DEPTH - 1);
   end

   // host side fills EP2, waits while the buffer is full
   task automatic load_ep2(input word_t w);
      while (ep2_q.size() >= EP_DEPTH)
         @(posedge fx2_clk);
      @(posedge fx2_clk);
      #1;
      ep2_q.push_back(w);
   endtask

   task automatic set_ep6_stall(input logic s);
      @(posedge fx2_clk);
      #1;
      ep6_stall = s;
   endtask

endmodule

/* verification/tb_fx2_usb_bridge.sv */
// Testbench for the FX2 USB bridge
// directed tests on both data paths, back-pressure and the forced
// packet end, with a behavioral FX2 on the USB side
module tb_fx2_usb_bridge import fx2_usb_pkg::*; ();

   localparam int FX2_PERIOD     = 8;
   localparam int SYS_PERIOD     = 10;
   localparam int SEED           = 30;
   localparam int TIMEOUT_CYCLES = 20000;
   // more than the receive FIFO holds, the rest stays in EP2
   localparam int BP_WORDS       = FIFO_DEPTH + 8;

   logic       fx2_clk;
   logic       clk_sys;
   logic       rst;
   word_t      out_data;
   logic       out_valid;
   logic       out_ready;
   word_t      in_data;
   logic       in_valid;
   logic       in_ready;
   fx2_flags_t fx2_flags;
   word_t      fx2_fd_in;
   word_t      fx2_fd_out;
   fx2_ctrl_t  fx2_ctrl;

   // expected streams, filled by the tests
   word_t exp_ep6[$];
   word_t exp_rcv[$];
   // words taken by the network in side
   word_t rcv_log[$];
   int    cycles = 0;

   initial begin
      fx2_clk = 1'b0;
      forever #(FX2_PERIOD / 2) fx2_clk = ~fx2_clk;
   end

   initial begin
      clk_sys = 1'b0;
      forever #(SYS_PERIOD / 2) clk_sys = ~clk_sys;
   end

   fx2_usb_bridge i_fx2_usb_bridge (.*);

   fx2_chip_model i_fx2 (.*);

   task automatic stop_run();
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
         stop_run();
      end
   endtask

   task automatic check_ctrl(input fx2_ctrl_t got, input fx2_ctrl_t exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
         stop_run();
      end
   endtask

   // whole run is bounded in fx2_clk cycles
   always @(posedge fx2_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d fx2_clk cycles, a test did not finish", cycles);
         stop_run();
      end
   end

   // strobe rules, mid-cycle where the controller outputs are stable
   always @(negedge fx2_clk) begin
      if (!rst && !fx2_ctrl.slwr)
         check_ctrl(fx2_ctrl, '{1'b1, 1'b0, 1'b1, fx2_ctrl.pktend, EP6_ADDR}, "write strobe");
      if (!rst && !fx2_ctrl.slrd)
         check_ctrl(fx2_ctrl, '{1'b0, 1'b1, 1'b0, fx2_ctrl.pktend, EP2_ADDR}, "read strobe");
   end

   // both sides high at the negedge means a transfer at the next edge
   always @(negedge clk_sys)
      if (!rst && in_valid && in_ready)
         rcv_log.push_back(in_data);

   task automatic send_word(input word_t w);
      @(posedge clk_sys);
      #1;
      out_valid = 1'b1;
      out_data  = w;
      @(negedge clk_sys);
      while (!out_ready)
         @(negedge clk_sys);
   endtask

   task automatic idle_out();
      @(posedge clk_sys);
      #1;
      out_valid = 1'b0;
   endtask

   task automatic set_in_ready(input logic r);
      @(posedge clk_sys);
      #1;
      in_ready = r;
   endtask

   task automatic check_ep6_stream();
      while (i_fx2.ep6_log.size() < exp_ep6.size())
         @(posedge fx2_clk);
      // a late duplicate would show up here
      repeat (8) @(posedge fx2_clk);
      check_word(word_t'(i_fx2.ep6_log.size()), word_t'(exp_ep6.size()), "EP6 word count");
      foreach (exp_ep6[i])
         check_word(i_fx2.ep6_log[i], exp_ep6[i], "EP6 word order");
   endtask

   task automatic check_rcv_stream();
      while (rcv_log.size() < exp_rcv.size())
         @(posedge clk_sys);
      repeat (8) @(posedge clk_sys);
      check_word(word_t'(rcv_log.size()), word_t'(exp_rcv.size()), "in side word count");
      foreach (exp_rcv[i])
         check_word(rcv_log[i], exp_rcv[i], "in side word order");
   endtask

   task automatic test_reset();
      @(negedge fx2_clk);
      check_ctrl(fx2_ctrl, '{1'b1, 1'b1, 1'b1, 1'b1, EP2_ADDR}, "control after reset");
      check_bit(in_valid, 1'b0, "in_valid after reset");
      @(negedge clk_sys);
      check_bit(out_ready, 1'b1, "out_ready after reset");
   endtask

   task automatic test_send();
      word_t w;
      for (int i = 0; i < 20; i++) begin
         w = word_t'($urandom());
         exp_ep6.push_back(w);
         send_word(w);
      end
      idle_out();
      check_ep6_stream();
   endtask

   task automatic test_receive();
      word_t w;
      set_in_ready(1'b1);
      for (int i = 0; i < 8; i++) begin
         w = word_t'($urandom());
         exp_rcv.push_back(w);
         i_fx2.load_ep2(w);
      end
      check_rcv_stream();
   endtask

   // EP6 stalled, fill the send FIFO until out_ready drops
   task automatic test_send_stall();
      word_t w;
      int    n;
      n = 0;
      i_fx2.set_ep6_stall(1'b1);
      repeat (4) @(posedge fx2_clk);
      w = word_t'($urandom());
      send_word(w);
      while (out_ready && n < 4 * FIFO_DEPTH) begin
         exp_ep6.push_back(w);
         n++;
         w = word_t'($urandom());
         @(posedge clk_sys);
         #1;
         out_data = w;
         @(negedge clk_sys);
      end
      // loop must end on a full FIFO and not on the word limit
      check_bit(out_ready, 1'b0, "out_ready with send FIFO full");
      idle_out();
      check_bit(n >= FIFO_DEPTH, 1'b1, "words accepted before out_ready dropped");
      repeat (20) @(posedge fx2_clk);
      check_word(word_t'(i_fx2.ep6_log.size()), word_t'(exp_ep6.size() - n),
                 "EP6 writes while stalled");
      i_fx2.set_ep6_stall(1'b0);
      check_ep6_stream();
   endtask

   // in_ready low, reads must stop once the receive FIFO is full
   task automatic test_rcv_backpressure();
      word_t w;
      int    base;
      set_in_ready(1'b0);
      base = exp_rcv.size();
      for (int i = 0; i < BP_WORDS; i++) begin
         w = word_t'($urandom());
         exp_rcv.push_back(w);
         i_fx2.load_ep2(w);
      end
      repeat (40) @(posedge fx2_clk);
      check_word(word_t'(i_fx2.ep2_q.size()), word_t'(BP_WORDS - FIFO_DEPTH),
                 "EP2 words left with receive FIFO full");
      // first word stays on the in side until the network takes it
      check_bit(in_valid, 1'b1, "in_valid held with in_ready low");
      check_word(in_data, exp_rcv[base], "in_data held with in_ready low");
      set_in_ready(1'b1);
      check_rcv_stream();
   endtask

   task automatic test_both();
      word_t ws[$];
      word_t wr[$];
      // drawn up front so the sequence does not depend on scheduling
      for (int i = 0; i < 24; i++) begin
         ws.push_back(word_t'($urandom()));
         wr.push_back(word_t'($urandom()));
         exp_ep6.push_back(ws[i]);
         exp_rcv.push_back(wr[i]);
      end
      fork
         begin
            foreach (ws[i])
               send_word(ws[i]);
            idle_out();
         end
         begin
            foreach (wr[i])
               i_fx2.load_ep2(wr[i]);
         end
      join
      check_ep6_stream();
      check_rcv_stream();
   endtask

   task automatic test_forced_pktend();
      word_t w;
      int    n0;
      int    lw;
      w = word_t'($urandom());
      exp_ep6.push_back(w);
      send_word(w);
      idle_out();
      check_ep6_stream();
      lw = i_fx2.last_wr_cycle;
      // first pulse logged after the last write
      n0 = i_fx2.pkt_log.size();
      while (n0 > 0 && i_fx2.pkt_log[n0 - 1] > lw)
         n0--;
      while (i_fx2.pkt_log.size() < n0 + 2)
         @(posedge fx2_clk);
      // timeout high cycles, then one low cycle, then again
      check_word(word_t'(i_fx2.pkt_log[n0] - lw), word_t'(FORCE_SEND_TIMEOUT + 1),
                 "cycles from last write to pktend");
      check_word(word_t'(i_fx2.pkt_log[n0 + 1] - i_fx2.pkt_log[n0]),
                 word_t'(FORCE_SEND_TIMEOUT + 1), "pktend repeat period");
   endtask

   initial begin
      void'($urandom(SEED));
      rst       = 1'b1;
      out_data  = '0;
      out_valid = 1'b0;
      in_ready  = 1'b0;
      repeat (5) @(posedge fx2_clk);
      #1;
      rst = 1'b0;
      test_reset();
      test_send();
      test_receive();
      test_send_stall();
      test_rcv_backpressure();
      test_both();
      test_forced_pktend();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* fx2_usb_bridge.f */
hdl/fx2_usb_pkg.sv
hdl/cdc_fifo.sv
hdl/fx2_slave_fifo_ctrl.sv
hdl/fx2_usb_bridge.sv
verification/fx2_chip_model.sv
verification/tb_fx2_usb_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the FX2 USB bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
   -f fx2_usb_bridge.f \
   --top-module tb_fx2_usb_bridge \
   -Mdir obj_dir -o sim_fx2_usb_bridge
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/sim_fx2_usb_bridge
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit $status
fi

exit 0
